//--- verilog/codec_bank_pkg.sv
// bank status flag type, bank pointer width and ring step helpers

package codec_bank_pkg;

  //------------------------------------------------------------
  // status flags of the bank ring
  //------------------------------------------------------------

  typedef struct packed {
    logic empty;      // any bank empty
    logic empty_all;  // all banks empty
    logic full;       // any bank full
    logic full_all;   // all banks full
  } bank_flags_t;

  // a single bank still needs a 1 bit pointer, held at 0
  function automatic int bank_ptr_w(input int bnum_w);
    return (bnum_w > 0) ? bnum_w : 1;
  endfunction

  // next bank in ring order, wraps at 2**bnum_w
  function automatic int bank_next(input int ptr, input int bnum_w);
    int nbank;
    nbank = 2**bnum_w;
    return (ptr + 1) % nbank;
  endfunction

endpackage

//--- verilog/codec_frame_pkg.sv
// frame sequencer state type and word position helpers

package codec_frame_pkg;

  // sequencer states of writer and reader
  typedef enum logic {
    seq_idle = 1'b0,  // waiting for a frame
    seq_run  = 1'b1   // stepping through a frame
  } frame_seq_t;

  // counter at its final value for a frame of 2**width words
  // caller zero-extends the counter to 32 bits
  function automatic logic is_last_word(input logic [31:0] cnt, input int width);
    logic [31:0] last;
    last = (32'd1 << width) - 32'd1;
    return (cnt == last);
  endfunction

  // counter at the first word of a frame
  function automatic logic is_first_word(input logic [31:0] cnt);
    return (cnt == 32'd0);
  endfunction

endpackage

//--- verilog/codec_buffer_ctrl_if.sv
// bank control interface with pointers, full/empty strobes, status flags and modports

`timescale 1ns/10ps

interface codec_buffer_ctrl_if
  import codec_bank_pkg::*;
#(
  parameter int pBNUM_W = 1  // 2**pBNUM_W banks
)
();

  localparam int cPTR_W = bank_ptr_w(pBNUM_W);

  //------------------------------------------------------------
  // signals
  //------------------------------------------------------------

  logic              wfull;   // last word of a frame written
  logic              rempty;  // last address of a frame read
  logic [cPTR_W-1:0] wused;   // bank under write
  logic [cPTR_W-1:0] rused;   // bank under read
  bank_flags_t       flags;   // registered ring status

  //------------------------------------------------------------
  // modports
  //------------------------------------------------------------

  // bank pointer logic owns pointers and flags
  modport logic_mp (
    input  wfull,
    input  rempty,
    output wused,
    output rused,
    output flags
  );

  modport wr_mp (
    output wfull,
    input  wused,
    input  flags
  );

  modport rd_mp (
    output rempty,
    input  rused,
    input  flags
  );

endinterface

//--- verilog/codec_buffer_nD_slogic.sv
// bank busy bits, write/read bank pointers and ring status flags

`timescale 1ns/10ps

module codec_buffer_nD_slogic
  import codec_bank_pkg::*;
#(
  parameter int pBNUM_W = 1  // 2**pBNUM_W banks
)
(
  input logic iclk,
  input logic ireset,
  input logic iclkena,
  codec_buffer_ctrl_if.logic_mp ctrl
);

  localparam int cBNUM  = 2**pBNUM_W;
  localparam int cPTR_W = bank_ptr_w(pBNUM_W);

  logic [cBNUM-1:0]  busy;   // one bit per bank, set = holds a full frame
  logic [cPTR_W-1:0] wused;
  logic [cPTR_W-1:0] rused;
  logic [cPTR_W-1:0] wnext;  // ring successors
  logic [cPTR_W-1:0] rnext;

  assign wnext = cPTR_W'(bank_next(int'(wused), pBNUM_W));
  assign rnext = cPTR_W'(bank_next(int'(rused), pBNUM_W));

  //------------------------------------------------------------
  // busy bits and pointers
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy  <= '0;
      wused <= '0;
      rused <= '0;
    end else if (iclkena) begin
      for (int i = 0; i < cBNUM; i++) begin
        if (ctrl.wfull && (int'(wused) == i)) begin
          busy[i] <= 1'b1;  // frame stored
        end else if (ctrl.rempty && (int'(rused) == i)) begin
          busy[i] <= 1'b0;  // frame drained
        end
      end
      // writer moves on if the next bank is free,
      // or sits on a full bank that a read is about to release
      if ((ctrl.wfull && ctrl.rempty) || (ctrl.wfull && !busy[wnext]) ||
          (ctrl.rempty && busy[wused])) begin
        wused <= wnext;
      end
      // reader follows the ring
      if ((ctrl.wfull && ctrl.rempty) || (ctrl.rempty && busy[rused])) begin
        rused <= rnext;
      end
    end
  end

  assign ctrl.wused = wused;
  assign ctrl.rused = rused;

  // busy banks are contiguous from rused
  assign ctrl.flags = '{
    empty:     |(~busy),
    empty_all: &(~busy),
    full:      |busy,
    full_all:  &busy
  };

  //------------------------------------------------------------
  // checks
  //------------------------------------------------------------

  // writer must not finish a frame into a full ring
  a_no_overfill : assert property (@(posedge iclk) disable iff (ireset)
    iclkena && ctrl.wfull && ctrl.flags.full_all |-> ctrl.rempty)
    else $error("slogic: frame completed while all banks full");

  // reader drains only banks that were filled
  a_no_underrun : assert property (@(posedge iclk) disable iff (ireset)
    iclkena && ctrl.rempty |-> ctrl.flags.full)
    else $error("slogic: frame drained while no bank full");

endmodule

//--- verilog/codec_buffer_ram.sv
// dual-port frame RAM with registered read, addressed by bank and word

`timescale 1ns/10ps

module codec_buffer_ram #(
  parameter int pBNUM_W = 1,  // 2**pBNUM_W banks
  parameter int pADDR_W = 4,  // 2**pADDR_W words per bank
  parameter int pDAT_W  = 8
)
(
  input  logic                       iclk,
  input  logic                       iclkena,  // read register follows the global enable
  input  logic                       iwena,
  input  logic [pBNUM_W+pADDR_W-1:0] iwaddr,   // {bank, word}
  input  logic [pDAT_W-1:0]          iwdat,
  input  logic [pBNUM_W+pADDR_W-1:0] iraddr,   // {bank, word}
  output logic [pDAT_W-1:0]          ordat
);

  localparam int cDEPTH = 2**(pBNUM_W + pADDR_W);

  logic [pDAT_W-1:0] mem [cDEPTH];  // all banks back to back

  //------------------------------------------------------------
  // write port and registered read port
  //------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (iwena) begin
        mem[iwaddr] <= iwdat;
      end
      ordat <= mem[iraddr];  // read before write on a collision
    end
  end

endmodule

//--- verilog/codec_frame_writer.sv
// frame writer: word counter, RAM write port, bank full strobe, busy flag

`timescale 1ns/10ps

module codec_frame_writer
  import codec_frame_pkg::*;
#(
  parameter int pBNUM_W = 1,
  parameter int pADDR_W = 4,
  parameter int pDAT_W  = 8
)
(
  input  logic                       iclk,
  input  logic                       ireset,
  input  logic                       iclkena,
  input  logic                       ival,
  input  logic [pDAT_W-1:0]          idat,
  output logic                       obusy,   // ring full, source holds off
  output logic                       owena,
  output logic [pBNUM_W+pADDR_W-1:0] owaddr,
  output logic [pDAT_W-1:0]          owdat,
  codec_buffer_ctrl_if.wr_mp ctrl
);

  localparam int cAW = pBNUM_W + pADDR_W;

  logic [pADDR_W-1:0] wcnt;  // word index inside frame
  logic               wlast;

  assign obusy = ctrl.flags.full_all;
  assign owena = ival && !obusy;  // word dropped while busy
  assign owdat = idat;

  // bank bit is dropped for a single bank ring
  assign owaddr = cAW'({ctrl.wused, wcnt});

  assign wlast      = is_last_word(32'(wcnt), pADDR_W);
  assign ctrl.wfull = iclkena && owena && wlast;  // frame complete

  //------------------------------------------------------------
  // word counter
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wcnt <= '0;
    end else if (iclkena && owena) begin
      wcnt <= wcnt + 1'b1;  // wraps to 0 after the last word
    end
  end

  // source respects the busy level
  a_no_val_busy : assert property (@(posedge iclk) disable iff (ireset)
    iclkena |-> !(ival && obusy))
    else $error("writer: ival while obusy, word dropped");

endmodule

//--- verilog/codec_frame_reader.sv
// frame reader: bank sequencer, RAM read address, framing strobes, bank empty strobe

`timescale 1ns/10ps

module codec_frame_reader
  import codec_frame_pkg::*;
#(
  parameter int pBNUM_W = 1,
  parameter int pADDR_W = 4,
  parameter int pDAT_W  = 8
)
(
  input  logic                       iclk,
  input  logic                       ireset,
  input  logic                       iclkena,
  input  logic [pDAT_W-1:0]          ordat_ram,  // registered RAM read data
  output logic [pBNUM_W+pADDR_W-1:0] oraddr,
  output logic                       oval,
  output logic                       osop,
  output logic                       oeop,
  output logic [pDAT_W-1:0]          odat,
  codec_buffer_ctrl_if.rd_mp ctrl
);

  localparam int cAW   = pBNUM_W + pADDR_W;
  localparam int cBNUM = 2**pBNUM_W;

  frame_seq_t         state;
  logic [pADDR_W-1:0] rcnt;    // word index inside frame
  logic               rd_act;  // address issued this cycle
  logic               rd_first;
  logic               rd_last;
  logic               rd_chain;  // another full bank waits behind this one

  //------------------------------------------------------------
  // address side
  //------------------------------------------------------------

  assign rd_act   = (state == seq_run);
  assign rd_first = rd_act && is_first_word(32'(rcnt));
  assign rd_last  = rd_act && is_last_word(32'(rcnt), pADDR_W);

  // ring is all full, so the next bank is full too
  assign rd_chain = (cBNUM > 1) && ctrl.flags.full_all;

  assign oraddr      = cAW'({ctrl.rused, rcnt});
  assign ctrl.rempty = iclkena && rd_last;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= seq_idle;
      rcnt  <= '0;
    end else if (iclkena) begin
      case (state)
        seq_idle : begin
          if (ctrl.flags.full) begin
            state <= seq_run;  // first address next cycle
          end
        end
        seq_run : begin
          rcnt <= rcnt + 1'b1;  // wraps to 0 at frame end
          if (rd_last && !rd_chain) begin
            state <= seq_idle;
          end
        end
        default : state <= seq_idle;
      endcase
    end
  end

  //------------------------------------------------------------
  // data side, one cycle behind the address
  //------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
    end else if (iclkena) begin
      oval <= rd_act;
      osop <= rd_first;
      oeop <= rd_last;
    end
  end

  assign odat = ordat_ram;  // RAM register already lines up

endmodule

//--- verilog/codec_buffer_top.sv
// frame buffer top level: control interface, bank logic, RAM, writer and reader

`timescale 1ns/10ps

module codec_buffer_top #(
  parameter int pBNUM_W = 1,  // 2**pBNUM_W banks
  parameter int pADDR_W = 4,  // 2**pADDR_W words per frame
  parameter int pDAT_W  = 8
)
(
  input  logic              iclk,
  input  logic              ireset,
  input  logic              iclkena,
  input  logic              ival,
  input  logic [pDAT_W-1:0] idat,
  output logic              obusy,
  output logic              oval,
  output logic              osop,
  output logic              oeop,
  output logic [pDAT_W-1:0] odat,
  output logic              oempty,   // any bank empty
  output logic              oemptya,  // all banks empty
  output logic              ofull,    // any bank full
  output logic              ofulla    // all banks full
);

  localparam int cAW = pBNUM_W + pADDR_W;

  // RAM ports
  logic              ram_wena;
  logic [cAW-1:0]    ram_waddr;
  logic [pDAT_W-1:0] ram_wdat;
  logic [cAW-1:0]    ram_raddr;
  logic [pDAT_W-1:0] ram_rdat;

  //------------------------------------------------------------
  // bank control
  //------------------------------------------------------------

  codec_buffer_ctrl_if #(.pBNUM_W(pBNUM_W)) ctrl_if ();

  codec_buffer_nD_slogic #(.pBNUM_W(pBNUM_W)) slogic_i (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ctrl    (ctrl_if.logic_mp)
  );

  assign oempty  = ctrl_if.flags.empty;
  assign oemptya = ctrl_if.flags.empty_all;
  assign ofull   = ctrl_if.flags.full;
  assign ofulla  = ctrl_if.flags.full_all;

  //------------------------------------------------------------
  // datapath
  //------------------------------------------------------------

  codec_frame_writer #(.pBNUM_W(pBNUM_W), .pADDR_W(pADDR_W), .pDAT_W(pDAT_W)) writer_i (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .idat    (idat),
    .obusy   (obusy),
    .owena   (ram_wena),
    .owaddr  (ram_waddr),
    .owdat   (ram_wdat),
    .ctrl    (ctrl_if.wr_mp)
  );

  codec_buffer_ram #(.pBNUM_W(pBNUM_W), .pADDR_W(pADDR_W), .pDAT_W(pDAT_W)) ram_i (
    .iclk    (iclk),
    .iclkena (iclkena),
    .iwena   (ram_wena),
    .iwaddr  (ram_waddr),
    .iwdat   (ram_wdat),
    .iraddr  (ram_raddr),
    .ordat   (ram_rdat)
  );

  codec_frame_reader #(.pBNUM_W(pBNUM_W), .pADDR_W(pADDR_W), .pDAT_W(pDAT_W)) reader_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .ordat_ram (ram_rdat),
    .oraddr    (ram_raddr),
    .oval      (oval),
    .osop      (osop),
    .oeop      (oeop),
    .odat      (odat),
    .ctrl      (ctrl_if.rd_mp)
  );

endmodule

//--- bench/codec_buffer_checker.sv
// output checker: word queue model, data/framing/stall/flag compares, error counts

`timescale 1ns/10ps

module codec_buffer_checker #(
  parameter int pBNUM_W = 1,  // 2**pBNUM_W banks
  parameter int pADDR_W = 4,  // 2**pADDR_W words per frame
  parameter int pDAT_W  = 8
)
(
  input logic              iclk,
  input logic              ireset,
  input logic              iclkena,
  input logic              ival,
  input logic [pDAT_W-1:0] idat,
  input logic              obusy,
  input logic              oval,
  input logic              osop,
  input logic              oeop,
  input logic [pDAT_W-1:0] odat,
  input logic              oempty,
  input logic              oemptya,
  input logic              ofull,
  input logic              ofulla
);

  localparam int cFRAME = 2**pADDR_W;
  localparam int cBNUM  = 2**pBNUM_W;

  logic [pDAT_W-1:0] word_q [$];  // accepted words, oldest first

  int words_in    = 0;
  int words_out   = 0;
  int in_pos      = 0;  // word index in frame under write
  int out_pos     = 0;  // word index in frame under read
  int frames_in   = 0;  // complete input frames
  int frames_out  = 0;  // output frames opened by osop
  int frames_done = 0;  // output frames read up to their last word
  int wait_cnt    = 0;  // enabled cycles with a waiting frame, no osop
  int err_reset   = 0;
  int err_data    = 0;
  int err_frame   = 0;
  int err_stall   = 0;
  int err_flag    = 0;

  // samples from the edge before
  logic              prev_reset = 1'b1;
  logic              prev_ena   = 1'b1;
  logic              prev_val;
  logic              prev_sop;
  logic              prev_eop;
  logic [pDAT_W-1:0] prev_dat;

  //------------------------------------------------------------
  // helpers
  //------------------------------------------------------------

  function automatic int compare_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected %b actual %b at %0t", name, exp_v, act_v, $time);
      return 1;
    end
    return 0;
  endfunction

  task automatic check_reset_state(input string when_s);
    err_reset += compare_bit({when_s, "_oval"}, 1'b0, oval);
    err_reset += compare_bit({when_s, "_osop"}, 1'b0, osop);
    err_reset += compare_bit({when_s, "_oeop"}, 1'b0, oeop);
    err_reset += compare_bit({when_s, "_obusy"}, 1'b0, obusy);
    err_reset += compare_bit({when_s, "_ofull"}, 1'b0, ofull);
    err_reset += compare_bit({when_s, "_oemptya"}, 1'b1, oemptya);
  endtask

  //------------------------------------------------------------
  // per edge model, sampled before the edge takes effect
  //------------------------------------------------------------

  always @(posedge iclk) begin : watch
    logic [pDAT_W-1:0] exp_dat;
    logic              pending;
    int                stored;  // full banks the model expects
    if (ireset) begin
      check_reset_state("reset");
      word_q.delete();
      in_pos      = 0;
      out_pos     = 0;
      frames_in   = 0;
      frames_out  = 0;
      frames_done = 0;
      wait_cnt    = 0;
    end else begin
      if (prev_reset) begin
        check_reset_state("after_reset");
      end
      // outputs hold across a disabled edge
      if (!prev_reset && !prev_ena) begin
        err_stall += compare_bit("stall_oval", prev_val, oval);
        err_stall += compare_bit("stall_osop", prev_sop, osop);
        err_stall += compare_bit("stall_oeop", prev_eop, oeop);
        if (odat !== prev_dat) begin
          $display("[FAIL] stall_odat: expected %h actual %h at %0t", prev_dat, odat, $time);
          err_stall++;
        end
      end
      // bank of the last word on the port is already free
      stored = frames_in - frames_done - ((oval && (out_pos == cFRAME - 1)) ? 1 : 0);
      err_flag += compare_bit("flag_busy", (stored == cBNUM), obusy);
      err_flag += compare_bit("flag_fulla", (stored == cBNUM), ofulla);
      err_flag += compare_bit("flag_anyfull", (stored > 0), ofull);
      err_flag += compare_bit("flag_empty", (stored < cBNUM), oempty);
      err_flag += compare_bit("flag_emptya", (stored == 0), oemptya);
      if (iclkena) begin
        if (oval) begin
          if (osop) begin
            if (out_pos != 0) begin
              $display("error: osop inside an output frame at %0t", $time);
              err_frame++;
            end
            if (frames_in <= frames_out) begin
              $display("error: output frame began before its input was complete at %0t", $time);
              err_frame++;
            end
            frames_out++;
            out_pos = 0;
          end else if (out_pos == 0) begin
            $display("error: first word of an output frame came without osop at %0t", $time);
            err_frame++;
          end
          err_frame += compare_bit("framing_eop", (out_pos == cFRAME - 1), oeop);
          if (word_q.size() == 0) begin
            $display("error: output word with no input word left in the model at %0t", $time);
            err_data++;
          end else begin
            exp_dat = word_q.pop_front();
            if (odat !== exp_dat) begin
              $display("[FAIL] data_order: expected %h actual %h at %0t", exp_dat, odat, $time);
              err_data++;
            end
          end
          words_out++;
          if (out_pos == cFRAME - 1) begin
            frames_done++;
          end
          out_pos = (out_pos + 1) % cFRAME;
        end else begin
          err_frame += compare_bit("framing_idle_sop", 1'b0, osop);
          err_frame += compare_bit("framing_idle_eop", 1'b0, oeop);
        end
        // a stored frame still waiting for the reader keeps ofull up
        pending  = (frames_in > frames_out);
        wait_cnt = (pending && !(oval && osop)) ? wait_cnt + 1 : 0;
        if (wait_cnt > 3) begin
          err_flag += compare_bit("flag_full", 1'b1, ofull);
        end
        // input side, word taken only when not busy
        if (ival && !obusy) begin
          word_q.push_back(idat);
          words_in++;
          in_pos++;
          if (in_pos == cFRAME) begin
            frames_in++;
            in_pos = 0;
          end
        end
      end
    end
    prev_reset = ireset;
    prev_ena   = iclkena;
    prev_val   = oval;
    prev_sop   = osop;
    prev_eop   = oeop;
    prev_dat   = odat;
  end

  //------------------------------------------------------------
  // end of run, buffer must be drained
  //------------------------------------------------------------

  task automatic finish_checks(output int nerr);
    err_flag += compare_bit("drain_emptya", 1'b1, oemptya);
    if (word_q.size() != 0) begin
      $display("[FAIL] drain_queue: expected 0 actual %0d", word_q.size());
      err_data++;
    end
    if (in_pos != 0) begin
      $display("error: input stopped inside a frame, %0d words left over", in_pos);
      err_frame++;
    end
    nerr = err_reset + err_data + err_frame + err_stall + err_flag;
    $display("checker: in=%0d out=%0d frames=%0d errors reset=%0d data=%0d framing=%0d %s",
             words_in, words_out, frames_out, err_reset, err_data, err_frame,
             $sformatf("stall=%0d flags=%0d total=%0d", err_stall, err_flag, nerr));
  endtask

endmodule

//--- bench/tb_codec_buffer.sv
// testbench top: clock, reset, seeded random stimulus phases, watchdog, DUT and checker

`timescale 1ns/10ps

module tb_codec_buffer #(
  parameter int          pBNUM_W = 1,
  parameter int          pADDR_W = 4,
  parameter int          pDAT_W  = 8,
  parameter int unsigned pSEED   = 32'ha91438a1
);

  localparam int cFRAME     = 2**pADDR_W;
  localparam int cSPARSE    = 10 * cFRAME;  // words of the sparse phase
  localparam int cDENSE     = 30 * cFRAME;  // words of the dense phase
  localparam int cTOTAL     = cSPARSE + cDENSE;
  localparam int cPERIOD    = 40;           // ns
  localparam int cRESET_CYC = 16;
  localparam int cLIMIT_CYC = cTOTAL * 4 + 2000;

  logic              iclk = 1'b0;
  logic              ireset;
  logic              iclkena;
  logic              ival;
  logic [pDAT_W-1:0] idat;
  logic              obusy;
  logic              oval;
  logic              osop;
  logic              oeop;
  logic [pDAT_W-1:0] odat;
  logic              oempty;
  logic              oemptya;
  logic              ofull;
  logic              ofulla;

  int accepted = 0;  // words the DUT took
  int offered  = 0;

  always #(cPERIOD / 2) iclk = ~iclk;

  //------------------------------------------------------------
  // DUT and checker
  //------------------------------------------------------------

  codec_buffer_top #(.pBNUM_W(pBNUM_W), .pADDR_W(pADDR_W), .pDAT_W(pDAT_W)) dut_i (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena), .ival (ival), .idat (idat),
    .obusy (obusy), .oval (oval), .osop (osop), .oeop (oeop), .odat (odat),
    .oempty (oempty), .oemptya (oemptya), .ofull (ofull), .ofulla (ofulla)
  );

  codec_buffer_checker #(.pBNUM_W(pBNUM_W), .pADDR_W(pADDR_W), .pDAT_W(pDAT_W)) chk_i (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena), .ival (ival), .idat (idat),
    .obusy (obusy), .oval (oval), .osop (osop), .oeop (oeop), .odat (odat),
    .oempty (oempty), .oemptya (oemptya), .ofull (ofull), .ofulla (ofulla)
  );

  //------------------------------------------------------------
  // one clock of stimulus
  //------------------------------------------------------------

  // offer_pct is the chance of a word per cycle, up to word_goal accepted words
  task automatic step_cycle(input int offer_pct, input int word_goal);
    bit took;
    bit frame_end;
    bit offer;
    @(posedge iclk);
    took = ival && iclkena && !obusy;  // what the DUT sees at this edge
    if (took) begin
      accepted++;
    end
    // a frame ends here, busy may rise right after this edge
    frame_end = took && ((accepted % cFRAME) == 0);
    offer = (accepted < word_goal) && !obusy && !frame_end &&
            (($urandom % 100) < offer_pct);
    if (offer) begin
      offered++;
    end
    iclkena <= (($urandom % 100) < 80);
    ival    <= offer;
    idat    <= pDAT_W'($urandom);
  endtask

  //------------------------------------------------------------
  // phases
  //------------------------------------------------------------

  initial begin : stimulus
    int nerr;
    ireset  = 1'b1;
    iclkena = 1'b1;
    ival    = 1'b0;
    idat    = '0;
    void'($urandom(pSEED));
    repeat (cRESET_CYC) @(posedge iclk);
    ireset <= 1'b0;
    while (accepted < cSPARSE) begin
      step_cycle(25, cSPARSE);  // reader keeps up
    end
    while (accepted < cTOTAL) begin
      step_cycle(100, cTOTAL);  // banks fill, obusy rises
    end
    // drain until nothing stored and the last word is gone
    do begin
      step_cycle(0, cTOTAL);
    end while (!(oemptya && !oval));
    repeat (4) step_cycle(0, cTOTAL);
    $display("stimulus: %0d words offered, %0d accepted", offered, accepted);
    chk_i.finish_checks(nerr);
    if (nerr == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // bound from the word count of all phases
  initial begin : watchdog
    #(longint'(cLIMIT_CYC) * cPERIOD);
    $display("timeout: run did not finish within %0d clock periods", cLIMIT_CYC);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- list.f
verilog/codec_bank_pkg.sv
verilog/codec_frame_pkg.sv
verilog/codec_buffer_ctrl_if.sv
verilog/codec_buffer_nD_slogic.sv
verilog/codec_buffer_ram.sv
verilog/codec_frame_writer.sv
verilog/codec_frame_reader.sv
verilog/codec_buffer_top.sv
bench/codec_buffer_checker.sv
bench/tb_codec_buffer.sv

//--- Makefile
# Verilator build and run of the multi-bank frame buffer testbench

VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= tb_codec_buffer
RTL_TOP   ?= codec_buffer_top
OBJ_DIR   ?= obj_dir
BNUM_W    ?= 1
ADDR_W    ?= 4
DAT_W     ?= 8
SEED      ?= 32'ha91438a1

PARAMS  = -GpBNUM_W=$(BNUM_W) -GpADDR_W=$(ADDR_W) -GpDAT_W=$(DAT_W)
VFLAGS ?= --binary --timing --assert -j 0
SIM     = ./$(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TB_TOP) $(PARAMS) \
	  "-GpSEED=$(SEED)" -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '** PASS **'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) $(PARAMS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
